/* fetch_pkg.sv */
//////////////////////////////////////////////////
// fetch package
// widths, memory geometry and the fetch-side bus types
//////////////////////////////////////////////////

package fetch_pkg;

	//////////////////////////////////////////////////
	// widths and geometry

	localparam int ADDR_WIDTH       = 64;			// pc / byte address
	localparam int INST_WIDTH       = 32;			// one instruction
	localparam int INST_BYTES       = INST_WIDTH / 8;	// pc step per instruction
	localparam int WORD_WIDTH       = 2 * INST_WIDTH;	// one memory word, two slots
	localparam int IMEM_INDEX_WIDTH = 8;
	localparam int IMEM_INDEX_LSB   = 3;			// word index is addr[10:3]
	localparam int IMEM_WORDS       = 1 << IMEM_INDEX_WIDTH;	// 256 words
	localparam int SLOT_SELECT_BIT  = 2;			// set -> pc points at upper slot

	//////////////////////////////////////////////////
	// bus types

	// two instructions per word, lower one at the aligned address
	typedef struct packed {
		logic [INST_WIDTH-1:0] upper;	// addr + 4
		logic [INST_WIDTH-1:0] lower;	// addr
	} fetch_slots_t;

	// memory side sees raw bits, fetch side sees the two slots
	typedef union packed {
		logic [WORD_WIDTH-1:0] raw;
		fetch_slots_t          slot;
	} fetch_word_u;

	typedef struct packed {
		logic                  taken;
		logic [ADDR_WIDTH-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic                        enable;	// write strobe, takes the port
		logic [IMEM_INDEX_WIDTH-1:0] index;
		fetch_word_u                 data;
	} imem_load_t;

	typedef struct packed {
		logic [INST_WIDTH-1:0] inst1;
		logic [INST_WIDTH-1:0] inst2;
		logic                  inst1_valid;
		logic                  inst2_valid;
		logic [ADDR_WIDTH-1:0] next_pc;
		logic                  thread;	// 0 = thread 1
	} fetch_bundle_t;

	// back end stall sources
	typedef struct packed {
		logic rs;
		logic rob;
		logic rat;
	} stall_t;

endpackage

/* thread_pkg.sv */
//////////////////////////////////////////////////
// thread package
// thread selection state and per-thread start pcs
//////////////////////////////////////////////////

package thread_pkg;

	// which thread owns the fetch port this cycle
	typedef enum logic {
		THREAD1_ACTIVE = 1'b0,
		THREAD2_ACTIVE = 1'b1
	} thread_state_e;

	// thread 1 boots from word 0
	localparam logic [fetch_pkg::ADDR_WIDTH-1:0] THREAD1_START_PC = 64'd0;

	// thread 2 boots from word 128, upper half of memory
	localparam logic [fetch_pkg::ADDR_WIDTH-1:0] THREAD2_START_PC = 64'd1024;

endpackage

/* pc_thread.sv */
//////////////////////////////////////////////////
// pc thread
// one thread's pc register and the pick of up to
// two instructions out of the fetched word
//////////////////////////////////////////////////

`timescale 1ns/10ps

module pc_thread #(
	parameter logic [fetch_pkg::ADDR_WIDTH-1:0] start_pc = thread_pkg::THREAD1_START_PC
) (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              enable,		// this thread owns the port
	input  fetch_pkg::redirect_t              redirect,		// strobe from the back end
	input  fetch_pkg::stall_t                 back_stall,
	input  logic                              mem_hazard,	// data side wants memory
	input  fetch_pkg::fetch_word_u            imem_data,
	input  logic                              imem_valid,
	output logic [fetch_pkg::ADDR_WIDTH-1:0]  pc,
	output logic [fetch_pkg::INST_WIDTH-1:0]  inst1,
	output logic [fetch_pkg::INST_WIDTH-1:0]  inst2,
	output logic                              inst1_valid,
	output logic                              inst2_valid,
	output logic [fetch_pkg::ADDR_WIDTH-1:0]  next_pc
);

	import fetch_pkg::*;

	logic                  stalled;		// any reason to hold the pc
	logic                  fetch_go;	// this cycle's word is really consumed
	logic                  half_aligned;	// pc sits on the upper slot
	logic [ADDR_WIDTH-1:0] pc_step;
	logic [ADDR_WIDTH-1:0] pc_next;

	//////////////////////////////////////////////////
	// fetch qualification

	assign stalled = back_stall.rs | back_stall.rob | back_stall.rat | mem_hazard;

	// a taken redirect kills whatever was read with the old pc
	assign fetch_go = enable & ~reset & ~stalled & imem_valid & ~redirect.taken;

	assign half_aligned = pc[SLOT_SELECT_BIT];

	//////////////////////////////////////////////////
	// instruction extraction

	always_comb
	begin
		if (half_aligned)
		begin
			inst1 = imem_data.slot.upper;	// only the upper slot is ours
		end
		else
		begin
			inst1 = imem_data.slot.lower;
		end
	end

	// second slot is always the upper one, flagged invalid when half aligned
	assign inst2 = imem_data.slot.upper;

	assign inst1_valid = fetch_go;
	assign inst2_valid = fetch_go & ~half_aligned;	// second slot only when aligned

	//////////////////////////////////////////////////
	// next pc

	// one instruction from a half word, two from an aligned one
	assign pc_step = half_aligned ? ADDR_WIDTH'(INST_BYTES) : ADDR_WIDTH'(2 * INST_BYTES);

	always_comb
	begin
		if (redirect.taken)
		begin
			pc_next = redirect.target;	// wins over stalls, even when idle
		end
		else if (fetch_go)
		begin
			pc_next = pc + pc_step;
		end
		else
		begin
			pc_next = pc;			// stall, port lost or not our turn
		end
	end

	assign next_pc = pc_next;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= start_pc;
		end
		else
		begin
			pc <= pc_next;
		end
	end

endmodule

/* if_stage.sv */
//////////////////////////////////////////////////
// instruction fetch stage
// two thread pcs sharing one memory port, picked
// in turn, and the fetch bundle for the back end
//////////////////////////////////////////////////

`timescale 1ns/10ps

module if_stage (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              two_threads,	// low -> thread 1 only
	input  fetch_pkg::redirect_t              thread1_redirect,
	input  fetch_pkg::redirect_t              thread2_redirect,
	input  fetch_pkg::stall_t                 back_stall,	// shared by both threads
	input  logic                              thread1_mem_hazard,
	input  logic                              thread2_mem_hazard,
	input  fetch_pkg::fetch_word_u            imem_data,
	input  logic                              imem_valid,
	output logic [fetch_pkg::ADDR_WIDTH-1:0]  imem_addr,
	output fetch_pkg::fetch_bundle_t          fetch,
	output logic                              thread1_available
);

	import fetch_pkg::*;
	import thread_pkg::*;

	thread_state_e         state;
	logic                  enable1;
	logic                  enable2;

	// per-thread results
	logic [ADDR_WIDTH-1:0] pc1_addr;
	logic [ADDR_WIDTH-1:0] pc2_addr;
	logic [INST_WIDTH-1:0] t1_inst1, t1_inst2;
	logic [INST_WIDTH-1:0] t2_inst1, t2_inst2;
	logic                  t1_inst1_valid, t1_inst2_valid;
	logic                  t2_inst1_valid, t2_inst2_valid;
	logic [ADDR_WIDTH-1:0] t1_next_pc;
	logic [ADDR_WIDTH-1:0] t2_next_pc;

	//////////////////////////////////////////////////
	// thread alternation

	// flips every edge, only looked at in two-thread mode
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= THREAD1_ACTIVE;
		end
		else
		begin
			state <= (state == THREAD1_ACTIVE) ? THREAD2_ACTIVE : THREAD1_ACTIVE;
		end
	end

	assign thread1_available = (state == THREAD1_ACTIVE);

	assign enable1 = ~two_threads | (state == THREAD1_ACTIVE);
	assign enable2 = two_threads & (state == THREAD2_ACTIVE);

	//////////////////////////////////////////////////
	// thread pcs

	pc_thread #(.start_pc(THREAD1_START_PC)) pc1 (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable1),
		.redirect    (thread1_redirect),
		.back_stall  (back_stall),
		.mem_hazard  (thread1_mem_hazard),
		.imem_data   (imem_data),
		.imem_valid  (imem_valid),
		.pc          (pc1_addr),
		.inst1       (t1_inst1),
		.inst2       (t1_inst2),
		.inst1_valid (t1_inst1_valid),
		.inst2_valid (t1_inst2_valid),
		.next_pc     (t1_next_pc)
	);

	pc_thread #(.start_pc(THREAD2_START_PC)) pc2 (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable2),
		.redirect    (thread2_redirect),
		.back_stall  (back_stall),
		.mem_hazard  (thread2_mem_hazard),
		.imem_data   (imem_data),
		.imem_valid  (imem_valid),
		.pc          (pc2_addr),
		.inst1       (t2_inst1),
		.inst2       (t2_inst2),
		.inst1_valid (t2_inst1_valid),
		.inst2_valid (t2_inst2_valid),
		.next_pc     (t2_next_pc)
	);

	//////////////////////////////////////////////////
	// port and bundle mux

	assign imem_addr = enable2 ? pc2_addr : pc1_addr;	// owner drives the port

	always_comb
	begin
		if (enable2)
		begin
			fetch.inst1       = t2_inst1;
			fetch.inst2       = t2_inst2;
			fetch.inst1_valid = t2_inst1_valid;
			fetch.inst2_valid = t2_inst2_valid;
			fetch.next_pc     = t2_next_pc;
			fetch.thread      = 1'b1;			// tag as thread 2
		end
		else
		begin
			fetch.inst1       = t1_inst1;
			fetch.inst2       = t1_inst2;
			fetch.inst1_valid = t1_inst1_valid;
			fetch.inst2_valid = t1_inst2_valid;
			fetch.next_pc     = t1_next_pc;
			fetch.thread      = 1'b0;
		end
	end

endmodule

/* imem.sv */
//////////////////////////////////////////////////
// instruction memory model
// 256 x 64 single port, zero-latency read, load port
//////////////////////////////////////////////////

`timescale 1ns/10ps

module imem (
	input  logic                             clock,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] addr,	// byte address from fetch
	input  fetch_pkg::imem_load_t            load,	// write port, from outside
	output fetch_pkg::fetch_word_u           data,
	output logic                             valid
);

	import fetch_pkg::*;

	logic [WORD_WIDTH-1:0]       mem [IMEM_WORDS];	// no reset, filled by load
	logic [IMEM_INDEX_WIDTH-1:0] read_index;

	//////////////////////////////////////////////////
	// read side

	// drop the byte offset, keep the word index
	assign read_index = addr[IMEM_INDEX_LSB +: IMEM_INDEX_WIDTH];

	// answers in the same cycle
	assign data.raw = mem[read_index];

	// one port only, a write cycle steals it from fetch
	assign valid = ~load.enable;

	//////////////////////////////////////////////////
	// write side

	always_ff @(posedge clock)
	begin
		if (load.enable)
		begin
			mem[load.index] <= load.data.raw;	// visible next cycle
		end
	end

endmodule

/* fetch_top.sv */
//////////////////////////////////////////////////
// fetch top
// fetch stage with its instruction memory
//////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_top (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     two_threads,
	input  fetch_pkg::redirect_t     thread1_redirect,
	input  fetch_pkg::redirect_t     thread2_redirect,
	input  fetch_pkg::stall_t        back_stall,
	input  logic                     thread1_mem_hazard,
	input  logic                     thread2_mem_hazard,
	input  fetch_pkg::imem_load_t    load,		// memory fill port
	output fetch_pkg::fetch_bundle_t fetch,
	output logic                     thread1_available
);

	import fetch_pkg::*;

	// fetch <-> memory
	logic [ADDR_WIDTH-1:0] imem_addr;
	fetch_word_u           imem_data;
	logic                  imem_valid;	// low on load cycles

	if_stage u_if_stage (
		.clock              (clock),
		.reset              (reset),
		.two_threads        (two_threads),
		.thread1_redirect   (thread1_redirect),
		.thread2_redirect   (thread2_redirect),
		.back_stall         (back_stall),
		.thread1_mem_hazard (thread1_mem_hazard),
		.thread2_mem_hazard (thread2_mem_hazard),
		.imem_data          (imem_data),
		.imem_valid         (imem_valid),
		.imem_addr          (imem_addr),
		.fetch              (fetch),
		.thread1_available  (thread1_available)
	);

	imem u_imem (
		.clock (clock),
		.addr  (imem_addr),
		.load  (load),
		.data  (imem_data),
		.valid (imem_valid)
	);

endmodule

/* tb_fetch_top.sv */
//////////////////////////////////////////////////
// fetch top testbench
// fills the memory, runs a stimulus table and
// checks every bundle against a reference model
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_fetch_top;

	import fetch_pkg::*;
	import thread_pkg::*;

	localparam int         RESET_CYCLES  = 16;
	localparam int         MARGIN_CYCLES = 50;
	localparam logic [2:0] STALL_NONE    = 3'b000;
	localparam logic [2:0] STALL_RS      = 3'b100;	// {rs, rob, rat}
	localparam logic [2:0] STALL_ROB     = 3'b010;
	localparam logic [2:0] STALL_RAT     = 3'b001;

	localparam redirect_t  NO_REDIRECT = '0;
	localparam imem_load_t NO_LOAD     = '0;

	// one table row, held for one cycle
	typedef struct packed {
		logic       two_threads;
		stall_t     back_stall;
		logic       hazard1;
		logic       hazard2;
		redirect_t  redirect1;
		redirect_t  redirect2;
		imem_load_t load;
	} stim_row_t;

	// what one thread should show this cycle
	typedef struct packed {
		logic                  v1;
		logic                  v2;
		logic [INST_WIDTH-1:0] i1;
		logic [INST_WIDTH-1:0] i2;
		logic [ADDR_WIDTH-1:0] npc;
	} expect_t;

	// dut side
	logic          clock = 1'b0;
	logic          reset;
	logic          two_threads;
	redirect_t     thread1_redirect;
	redirect_t     thread2_redirect;
	stall_t        back_stall;
	logic          thread1_mem_hazard;
	logic          thread2_mem_hazard;
	imem_load_t    load;
	fetch_bundle_t fetch;
	logic          thread1_available;

	// reference model state
	stim_row_t             cur;		// inputs applied this cycle
	logic                  cur_reset;
	logic [ADDR_WIDTH-1:0] m_pc1;
	logic [ADDR_WIDTH-1:0] m_pc2;
	thread_state_e         m_state;
	logic [WORD_WIDTH-1:0] m_mem [IMEM_WORDS];	// copy of the dut memory

	stim_row_t rows[$];
	integer    seed;
	int        errors;
	int        cycle_count = 0;
	int        cycle_limit;

	fetch_top dut (
		.clock              (clock),
		.reset              (reset),
		.two_threads        (two_threads),
		.thread1_redirect   (thread1_redirect),
		.thread2_redirect   (thread2_redirect),
		.back_stall         (back_stall),
		.thread1_mem_hazard (thread1_mem_hazard),
		.thread2_mem_hazard (thread2_mem_hazard),
		.load               (load),
		.fetch              (fetch),
		.thread1_available  (thread1_available)
	);

	always #10 clock = ~clock;	// 20 ns period

	// watchdog, limit set from the table size at time 0
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$fatal(1, "watchdog expired");
		end
	end

	//////////////////////////////////////////////////
	// row builders

	function automatic redirect_t jump(input logic [ADDR_WIDTH-1:0] target);
		redirect_t r;
		r.taken  = 1'b1;
		r.target = target;
		return r;
	endfunction

	function automatic imem_load_t write_word(input int index, input logic [WORD_WIDTH-1:0] data);
		imem_load_t ld;
		ld.enable   = 1'b1;
		ld.index    = IMEM_INDEX_WIDTH'(index);
		ld.data.raw = data;
		return ld;
	endfunction

	function automatic stim_row_t make_row(input logic two, input logic [2:0] stall,
			input logic h1, input logic h2, input redirect_t r1, input redirect_t r2,
			input imem_load_t ld);
		stim_row_t row;
		row.two_threads = two;
		row.back_stall  = stall_t'(stall);
		row.hazard1     = h1;
		row.hazard2     = h2;
		row.redirect1   = r1;
		row.redirect2   = r2;
		row.load        = ld;
		return row;
	endfunction

	//////////////////////////////////////////////////
	// reference model

	function automatic logic thread2_selected();
		return cur.two_threads & (m_state == THREAD2_ACTIVE);
	endfunction

	// one thread's fetch under the current inputs
	function automatic expect_t predict(input logic [ADDR_WIDTH-1:0] pc, input logic enabled,
			input redirect_t rd, input logic hazard);
		expect_t               e;
		logic                  stalled;
		logic                  go;
		logic [WORD_WIDTH-1:0] word;
		stalled = cur.back_stall.rs | cur.back_stall.rob | cur.back_stall.rat | hazard;
		go      = enabled & ~cur_reset & ~stalled & ~cur.load.enable & ~rd.taken;	// port lost on load
		word    = m_mem[pc[10:3]];
		e.i1    = pc[2] ? word[63:32] : word[31:0];	// half aligned starts in the upper slot
		e.i2    = word[63:32];
		e.v1    = go;
		e.v2    = go & ~pc[2];
		if (rd.taken)
			e.npc = rd.target;			// redirect beats everything
		else if (go)
			e.npc = pc + (pc[2] ? 64'd4 : 64'd8);
		else
			e.npc = pc;
		return e;
	endfunction

	// advance the model across one rising edge
	task automatic step_model();
		expect_t e1;
		expect_t e2;
		logic    sel2;
		sel2 = thread2_selected();
		e1   = predict(m_pc1, ~sel2, cur.redirect1, cur.hazard1);
		e2   = predict(m_pc2, sel2, cur.redirect2, cur.hazard2);
		if (cur_reset)
		begin
			m_pc1   = THREAD1_START_PC;
			m_pc2   = THREAD2_START_PC;
			m_state = THREAD1_ACTIVE;
		end
		else
		begin
			m_pc1   = e1.npc;
			m_pc2   = e2.npc;
			m_state = (m_state == THREAD1_ACTIVE) ? THREAD2_ACTIVE : THREAD1_ACTIVE;
		end
		if (cur.load.enable)
			m_mem[cur.load.index] = cur.load.data.raw;	// lands at this edge
	endtask

	//////////////////////////////////////////////////
	// checking

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic check_outputs();
		expect_t e;
		logic    sel2;
		sel2 = thread2_selected();
		if (sel2)
			e = predict(m_pc2, 1'b1, cur.redirect2, cur.hazard2);
		else
			e = predict(m_pc1, 1'b1, cur.redirect1, cur.hazard1);
		check_value("fetch.inst1_valid", 64'(fetch.inst1_valid), 64'(e.v1));
		check_value("fetch.inst2_valid", 64'(fetch.inst2_valid), 64'(e.v2));
		check_value("fetch.next_pc", fetch.next_pc, e.npc);
		check_value("fetch.thread", 64'(fetch.thread), 64'(sel2));
		check_value("thread1_available", 64'(thread1_available),
			64'(m_state == THREAD1_ACTIVE));
		if (e.v1)
			check_value("fetch.inst1", 64'(fetch.inst1), 64'(e.i1));
		if (e.v2)
			check_value("fetch.inst2", 64'(fetch.inst2), 64'(e.i2));
	endtask

	// drive one row at the edge, check at the falling edge
	task automatic run_cycle(input stim_row_t r, input logic rst);
		@(posedge clock);
		step_model();
		cur       = r;
		cur_reset = rst;
		reset              <= rst;
		two_threads        <= r.two_threads;
		back_stall         <= r.back_stall;
		thread1_mem_hazard <= r.hazard1;
		thread2_mem_hazard <= r.hazard2;
		thread1_redirect   <= r.redirect1;
		thread2_redirect   <= r.redirect2;
		load               <= r.load;
		@(negedge clock);
		check_outputs();
	endtask

	//////////////////////////////////////////////////
	// stimulus table

	task automatic build_table();
		stim_row_t plain1;
		stim_row_t plain2;
		plain1 = make_row(1'b0, STALL_NONE, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT, NO_LOAD);
		plain2 = make_row(1'b1, STALL_NONE, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT, NO_LOAD);
		repeat (4) rows.push_back(plain1);	// thread 1 straight from address 0
		rows.push_back(make_row(1'b0, STALL_RS, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT, NO_LOAD));
		rows.push_back(make_row(1'b0, STALL_ROB, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT, NO_LOAD));
		rows.push_back(make_row(1'b0, STALL_RAT, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT, NO_LOAD));
		rows.push_back(make_row(1'b0, STALL_NONE, 1'b1, 1'b0, NO_REDIRECT, NO_REDIRECT, NO_LOAD));
		// other thread's hazard must not hold thread 1
		rows.push_back(make_row(1'b0, STALL_NONE, 1'b0, 1'b1, NO_REDIRECT, NO_REDIRECT, NO_LOAD));
		repeat (2) rows.push_back(plain1);
		// jump onto an upper slot, then aligned again
		rows.push_back(make_row(1'b0, STALL_NONE, 1'b0, 1'b0, jump(64'h104), NO_REDIRECT, NO_LOAD));
		repeat (2) rows.push_back(plain1);
		// redirect during a stall still moves the pc
		rows.push_back(make_row(1'b0, STALL_ROB, 1'b0, 1'b0, jump(64'h40), NO_REDIRECT, NO_LOAD));
		rows.push_back(plain1);
		// two-thread mode, thread 2 starts at 1024
		repeat (6) rows.push_back(plain2);
		// thread 2 owns this cycle, thread 1 jumps while idle
		rows.push_back(make_row(1'b1, STALL_NONE, 1'b0, 1'b0, jump(64'h80), jump(64'h424),
			NO_LOAD));
		repeat (5) rows.push_back(plain2);
		rows.push_back(make_row(1'b1, STALL_NONE, 1'b0, 1'b1, NO_REDIRECT, NO_REDIRECT, NO_LOAD));
		repeat (2) rows.push_back(plain2);
		// load steals the port, new word visible next cycle
		rows.push_back(make_row(1'b0, STALL_NONE, 1'b0, 1'b0, jump(64'h200), NO_REDIRECT, NO_LOAD));
		rows.push_back(make_row(1'b0, STALL_NONE, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT,
			write_word(64, 64'h0123_4567_89ab_cdef)));
		rows.push_back(plain1);
		rows.push_back(make_row(1'b0, STALL_NONE, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT,
			write_word(65, 64'h5a5a_0f0f_a5a5_f0f0)));
		repeat (2) rows.push_back(plain1);
	endtask

	//////////////////////////////////////////////////
	// main sequence

	initial
	begin
		stim_row_t fill_row;
		seed               = 32'hf2e6c999;
		errors             = 0;
		reset              = 1'b1;
		two_threads        = 1'b0;
		thread1_redirect   = NO_REDIRECT;
		thread2_redirect   = NO_REDIRECT;
		back_stall         = '0;
		thread1_mem_hazard = 1'b0;
		thread2_mem_hazard = 1'b0;
		load               = NO_LOAD;
		cur                = '0;
		cur_reset          = 1'b1;
		m_pc1              = THREAD1_START_PC;
		m_pc2              = THREAD2_START_PC;
		m_state            = THREAD1_ACTIVE;
		build_table();
		cycle_limit = rows.size() + RESET_CYCLES + IMEM_WORDS + MARGIN_CYCLES;
		// fill every word, reset drops after the 16th edge
		for (int i = 0; i < IMEM_WORDS; i++)
		begin
			fill_row = make_row(1'b0, STALL_NONE, 1'b0, 1'b0, NO_REDIRECT, NO_REDIRECT,
				write_word(i, {$random(seed), $random(seed)}));
			run_cycle(fill_row, i < RESET_CYCLES - 1);
		end
		foreach (rows[i])
			run_cycle(rows[i], 1'b0);
		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* fetch_top.f */
fetch_pkg.sv
thread_pkg.sv
pc_thread.sv
if_stage.sv
imem.sv
fetch_top.sv
tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# compile the fetch_top testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_fetch_top
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/10ps \
	-f fetch_top.f --top-module "$TOP" -o "$TOP"; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?

if ! cat "$LOG"; then
	echo "cannot read $LOG"
	exit 1
fi

# the testbench prints its verdict, look for the failing one first
if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "result: simulation reported a failure"
	exit 1
fi

if [ "$run_status" -ne 0 ] || ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "result: simulation ended abnormally (status $run_status)"
	exit 1
fi

echo "result: simulation passed"
exit 0
